//--- Makefile
# Verilator build and run for the trigger-bit receiver testbench

TOP := tb_sbit_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	@if grep -q "Simulation finished: FAIL" run.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" run.log

clean:
	rm -rf obj_dir run.log

//--- frame_aligner.sv
// per-chip frame aligner: input registers, sof tap search, lock run,
// deserializer and output gating

`default_nettype none

`include "sbit_config.svh"

module frame_aligner
  import sbit_pkg::*;
(
  input  logic       fastclock,
  input  logic       reset,
  input  pin_word_t  data_pins,
  input  logic       sof_line,
  input  logic       mask,
  output sbit_word_t sbits,
  output logic       sbits_strobe,
  output logic       aligned,
  output logic       unstable
);

  localparam int PHASE_W = $clog2(`SBIT_FRAME_LEN);
  localparam int CHK_W   = (`SBIT_CHECK_FRAMES > 1) ? $clog2(`SBIT_CHECK_FRAMES) : 1;
  localparam int LOCK_W  = $clog2(`SBIT_LOCK_FRAMES + 1);

  // --------------------
  // input registers
  // --------------------
  pin_word_t pins_ff;
  logic      sof_ff;

  always_ff @(posedge fastclock) begin
    pins_ff <= data_pins;
    sof_ff  <= sof_line;
  end

  // --------------------
  // delay lines
  // --------------------
  tap_t      tap;
  pin_word_t pins_dly;
  logic      sof_dly;

  // data and sof see the same tap so they stay bit-aligned
  frame_delay_line #(.payload_t(pin_word_t)) u_data_dly (
    .fastclock (fastclock),
    .reset     (reset),
    .tap       (tap),
    .din       (pins_ff),
    .dout      (pins_dly)
  );

  frame_delay_line #(.payload_t(logic)) u_sof_dly (
    .fastclock (fastclock),
    .reset     (reset),
    .tap       (tap),
    .din       (sof_ff),
    .dout      (sof_dly)
  );

  // local frame boundary from a free-running phase counter
  logic [PHASE_W-1:0] phase;
  logic               frame_start;

  always_ff @(posedge fastclock) begin
    if (reset) begin
      phase <= '0;
    end else if (phase == PHASE_W'(`SBIT_FRAME_LEN - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign frame_start = (phase == '0);

  // --------------------
  // sof edge and tap search
  // --------------------
  // two low cycles before the high, so an inverted sof pair never locks
  logic sof_last;
  logic sof_last_last;
  logic sof_aligned;

  always_ff @(posedge fastclock) begin
    sof_last      <= sof_dly;
    sof_last_last <= sof_last;
  end

  assign sof_aligned = sof_dly && !sof_last && !sof_last_last;

  // check point every few frames, earlier tap changes have settled by then
  logic [CHK_W-1:0] check_cnt;
  logic             check_point;

  assign check_point = frame_start && (check_cnt == '0);

  always_ff @(posedge fastclock) begin
    if (reset) begin
      check_cnt <= '0;
      tap       <= '0;
    end else begin
      if (frame_start) begin
        if (check_cnt == CHK_W'(`SBIT_CHECK_FRAMES - 1)) begin
          check_cnt <= '0;
        end else begin
          check_cnt <= check_cnt + 1'b1;
        end
      end
      // step to the next tap, wraps past the last stage
      if (check_point && !sof_aligned) begin
        tap <= tap + 1'b1;
      end
    end
  end

  // --------------------
  // lock run and unstable flag
  // --------------------
  logic [LOCK_W-1:0] lock_cnt;
  logic              lock_ok;

  // true on the frame that completes the run, and on every aligned frame after
  assign lock_ok = sof_aligned && (lock_cnt >= LOCK_W'(`SBIT_LOCK_FRAMES - 1));

  always_ff @(posedge fastclock) begin
    if (reset) begin
      lock_cnt <= '0;
      aligned  <= 1'b0;
      unstable <= 1'b0;
    end else if (frame_start) begin
      if (!sof_aligned) begin
        lock_cnt <= '0;
      end else if (lock_cnt < LOCK_W'(`SBIT_LOCK_FRAMES)) begin
        lock_cnt <= lock_cnt + 1'b1;
      end
      aligned <= lock_ok;
      // sticky, only reset clears it
      if (aligned && !sof_aligned) begin
        unstable <= 1'b1;
      end
    end
  end

  // --------------------
  // deserializer
  // --------------------
  logic [`SBIT_FRAME_LEN-1:0] pin_shreg [`SBIT_NUM_PINS];
  sbit_word_t                 frame_word;

  // first bit of the frame ends up in the msb after a full frame
  always_ff @(posedge fastclock) begin
    for (int p = 0; p < `SBIT_NUM_PINS; p++) begin
      pin_shreg[p] <= {pin_shreg[p][`SBIT_FRAME_LEN-2:0], pins_dly[p]};
    end
  end

  // pin 0 in the low byte, pin 7 in the top byte
  always_comb begin
    for (int p = 0; p < `SBIT_NUM_PINS; p++) begin
      frame_word[p*`SBIT_FRAME_LEN +: `SBIT_FRAME_LEN] = pin_shreg[p];
    end
  end

  // at frame_start the shift registers hold the whole previous frame
  // gating follows the new aligned value, so a zero word goes with aligned low
  always_ff @(posedge fastclock) begin
    if (reset) begin
      sbits        <= '0;
      sbits_strobe <= 1'b0;
    end else begin
      sbits_strobe <= frame_start;
      if (frame_start) begin
        sbits <= (mask || !lock_ok) ? '0 : frame_word;
      end
    end
  end

endmodule

`default_nettype wire

//--- frame_delay_line.sv
// adjustable delay line with registered output
// payload type is a parameter so data pins and sof share the same code

`default_nettype none

`include "sbit_config.svh"

module frame_delay_line
  import sbit_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     fastclock,
  input  logic     reset,
  input  tap_t     tap,
  input  payload_t din,
  output payload_t dout
);

  // shreg[k] holds din from k cycles ago
  // tap 0 takes din directly, so total latency is tap + 1
  payload_t shreg [1:`SBIT_DLY_DEPTH-1];

  // --------------------
  // shift stages
  // --------------------
  always_ff @(posedge fastclock) begin
    shreg[1] <= din;
    for (int k = 2; k < `SBIT_DLY_DEPTH; k++) begin
      shreg[k] <= shreg[k-1];
    end
  end

  // --------------------
  // tap select and output register
  // --------------------
  always_ff @(posedge fastclock) begin
    if (reset) begin
      dout <= '0;
    end else if (tap == '0) begin
      dout <= din;
    end else begin
      dout <= shreg[tap];
    end
  end

endmodule

`default_nettype wire

//--- sbit_checker.sv
// checker for the trigger-bit receiver: lock, word sequence, masking,
// strobe spacing, unstable flag and per-test error counts

`default_nettype none

`include "sbit_config.svh"

module sbit_checker
  import sbit_pkg::*;
(
  input  logic                              fastclock,
  input  logic                              reset,
  input  sbit_word_t [`SBIT_NUM_VFAT-1:0]   sbits,
  input  logic       [`SBIT_NUM_VFAT-1:0]   sbits_strobe,
  input  logic       [`SBIT_NUM_VFAT-1:0]   aligned,
  input  logic       [`SBIT_NUM_VFAT-1:0]   unstable,
  input  logic       [`SBIT_NUM_VFAT-1:0]   mask,
  input  logic       [`SBIT_NUM_VFAT-1:0]   expect_unstable,
  input  int                                test_id,
  input  sbit_word_t                        base,
  input  logic                              test_end,
  output int                                error_count,
  output int                                failed_tests
);

  timeunit 1ns;
  timeprecision 100ps;

  sbit_word_t prev_word [`SBIT_NUM_VFAT];
  logic       prev_valid [`SBIT_NUM_VFAT];
  logic       seen_aligned [`SBIT_NUM_VFAT];
  logic       seen_unstable [`SBIT_NUM_VFAT];
  int         data_words [`SBIT_NUM_VFAT];
  // cycles since the last strobe, negative until the first one
  int         strobe_gap [`SBIT_NUM_VFAT];
  int         test_errors;

  // legal word: every byte is its base byte plus the same frame count
  function automatic logic legal_word(sbit_word_t w, sbit_word_t b);
    logic [7:0] k;
    k = w[7:0] - b[7:0];
    for (int p = 1; p < `SBIT_NUM_PINS; p++) begin
      if (w[p*8 +: 8] - b[p*8 +: 8] != k) return 1'b0;
    end
    return 1'b1;
  endfunction

  // successor: every byte one higher, wrapping at 256
  function automatic logic next_word(sbit_word_t w, sbit_word_t prev);
    for (int p = 0; p < `SBIT_NUM_PINS; p++) begin
      if (w[p*8 +: 8] != prev[p*8 +: 8] + 8'd1) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic value_error(int c, string msg);
    $display("[ERROR] %0t: test %0d chip %0d %s", $time, test_id, c, msg);
    test_errors++;
    error_count++;
  endtask

  initial begin
    error_count  = 0;
    failed_tests = 0;
    test_errors  = 0;
  end

  // --------------------
  // per-cycle checks
  // --------------------
  always @(posedge fastclock) begin
    if (reset) begin
      for (int c = 0; c < `SBIT_NUM_VFAT; c++) begin
        prev_valid[c]    = 1'b0;
        seen_aligned[c]  = 1'b0;
        seen_unstable[c] = 1'b0;
        data_words[c]    = 0;
        strobe_gap[c]    = -1;
      end
    end else begin
      for (int c = 0; c < `SBIT_NUM_VFAT; c++) begin
        if (aligned[c]) seen_aligned[c] = 1'b1;
        // sticky flag, may only fall with reset
        if (unstable[c]) begin
          seen_unstable[c] = 1'b1;
        end else if (seen_unstable[c]) begin
          value_error(c, "unstable fell before reset");
        end
        // one strobe per frame, a fixed frame length apart
        if (strobe_gap[c] >= 0) strobe_gap[c]++;
        if (!sbits_strobe[c] && strobe_gap[c] == `SBIT_FRAME_LEN) begin
          value_error(c, "strobe missing at the frame boundary");
        end
        if (sbits_strobe[c]) begin
          if (strobe_gap[c] >= 0 && strobe_gap[c] != `SBIT_FRAME_LEN) begin
            value_error(c, $sformatf("strobe after %0d cycles, expected %0d",
                                     strobe_gap[c], `SBIT_FRAME_LEN));
          end
          strobe_gap[c] = 0;
          if (mask[c] || !aligned[c]) begin
            if (sbits[c] != '0) value_error(c, $sformatf("word %h, expected zero", sbits[c]));
            prev_valid[c] = 1'b0;
          end else begin
            if (!legal_word(sbits[c], base)) begin
              value_error(c, $sformatf("word %h is not a frame word", sbits[c]));
            end else if (prev_valid[c] && !next_word(sbits[c], prev_word[c])) begin
              value_error(c, $sformatf("word %h does not follow %h", sbits[c], prev_word[c]));
            end
            prev_word[c]  = sbits[c];
            prev_valid[c] = 1'b1;
            data_words[c]++;
          end
        end
      end

      // end of test summary
      if (test_end) begin
        for (int c = 0; c < `SBIT_NUM_VFAT; c++) begin
          if (!mask[c] && !seen_aligned[c]) begin
            $display("test %0d: chip %0d never locked within the timeout", test_id, c);
            test_errors++;
            error_count++;
          end else if (!mask[c] && data_words[c] == 0) begin
            $display("test %0d: chip %0d delivered no data words", test_id, c);
            test_errors++;
            error_count++;
          end
          if (seen_unstable[c] != expect_unstable[c]) begin
            value_error(c, $sformatf("unstable seen %0d, expected %0d",
                                     seen_unstable[c], expect_unstable[c]));
          end
        end
        if (test_errors == 0) begin
          $display("test %0d: ok", test_id);
        end else begin
          $display("test %0d: failed with %0d errors", test_id, test_errors);
          failed_tests++;
        end
        test_errors = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- sbit_config.svh
// shared sizing macros for the trigger-bit receiver
// pin count, frame length, chip count, delay depth and lock timing

`ifndef SBIT_CONFIG_SVH
`define SBIT_CONFIG_SVH

// serial trigger pins per front-end chip
`define SBIT_NUM_PINS 8

// bits per pin in one frame, one bit per fastclock cycle
`define SBIT_FRAME_LEN 8

// chips handled by the top level
`define SBIT_NUM_VFAT 2

// delay line depth, also the number of selectable taps
`define SBIT_DLY_DEPTH 16

// consecutive aligned frames before lock (short value for simulation)
`define SBIT_LOCK_FRAMES 16

// frames between tap changes, lets the delay line settle
`define SBIT_CHECK_FRAMES 4

`endif

//--- sbit_pkg.sv
// shared types for the trigger-bit receiver
// pin word, deserialized frame word and delay tap address

`default_nettype none

`include "sbit_config.svh"

package sbit_pkg;

  // one bit per serial pin, sampled in one cycle
  typedef logic [`SBIT_NUM_PINS-1:0] pin_word_t;

  // one frame of one chip
  // pin 7 in the top byte, first received bit is the msb of each byte
  typedef logic [`SBIT_NUM_PINS*`SBIT_FRAME_LEN-1:0] sbit_word_t;

  // delay tap address, covers every stage of the delay line
  typedef logic [$clog2(`SBIT_DLY_DEPTH)-1:0] tap_t;

endpackage

`default_nettype wire

//--- sbit_rx_top.sv
// receiver top level, one frame aligner per chip
// all chips share fastclock and reset

`default_nettype none

`include "sbit_config.svh"

module sbit_rx_top
  import sbit_pkg::*;
(
  input  logic                                fastclock,
  input  logic                                reset,

  // per-chip inputs, index is the chip number
  input  pin_word_t  [`SBIT_NUM_VFAT-1:0]     data_pins,
  input  logic       [`SBIT_NUM_VFAT-1:0]     sof_line,
  input  logic       [`SBIT_NUM_VFAT-1:0]     mask,

  // per-chip outputs
  output sbit_word_t [`SBIT_NUM_VFAT-1:0]     sbits,
  output logic       [`SBIT_NUM_VFAT-1:0]     sbits_strobe,
  output logic       [`SBIT_NUM_VFAT-1:0]     aligned,
  output logic       [`SBIT_NUM_VFAT-1:0]     unstable
);

  // --------------------
  // aligner array
  // --------------------
  // chips are independent, each finds its own tap
  for (genvar i = 0; i < `SBIT_NUM_VFAT; i++) begin : g_vfat
    frame_aligner u_frame_aligner (
      .fastclock    (fastclock),
      .reset        (reset),
      .data_pins    (data_pins[i]),
      .sof_line     (sof_line[i]),
      .mask         (mask[i]),
      .sbits        (sbits[i]),
      .sbits_strobe (sbits_strobe[i]),
      .aligned      (aligned[i]),
      .unstable     (unstable[i])
    );
  end

endmodule

`default_nettype wire

//--- sbit_stim.txt
# id off0 off1 mask(hex, bit per chip) base(hex, 64 bit) frames shift0
# shift0 is chip 0's new sof offset mid-run, 8 means no shift
1 0 0 0 0011223344556677 40 8
2 1 5 0 08192a3b4c5d6e7f 40 8
3 2 6 0 f0e1d2c3b4a59687 40 8
4 3 7 0 0102030405060708 40 8
5 4 0 0 fefdfcfbfaf9f8f7 40 8
6 5 1 0 123456789abcdef0 40 8
7 6 2 0 a5a55a5a3c3cc3c3 40 8
8 7 3 0 0000000000000000 40 8
9 2 4 1 1111111111111111 40 8
10 5 3 2 7766554433221100 40 8
11 3 1 0 2040608090a0c0e0 60 6
12 0 7 0 ffffffffffffffff 60 2

//--- sim.f
+incdir+.
sbit_pkg.sv
frame_delay_line.sv
frame_aligner.sv
sbit_rx_top.sv
sbit_checker.sv
tb_sbit_rx.sv

//--- tb_sbit_rx.sv
// testbench top for the trigger-bit receiver: clock, reset, stimulus file,
// serial stream generation and the closing summary

`default_nettype none

`include "sbit_config.svh"

module tb_sbit_rx
  import sbit_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOCK_TIMEOUT = 1500;

  logic                                fastclock;
  logic                                reset;
  pin_word_t  [`SBIT_NUM_VFAT-1:0]     data_pins;
  logic       [`SBIT_NUM_VFAT-1:0]     sof_line;
  logic       [`SBIT_NUM_VFAT-1:0]     mask;
  sbit_word_t [`SBIT_NUM_VFAT-1:0]     sbits;
  logic       [`SBIT_NUM_VFAT-1:0]     sbits_strobe;
  logic       [`SBIT_NUM_VFAT-1:0]     aligned;
  logic       [`SBIT_NUM_VFAT-1:0]     unstable;

  logic       [`SBIT_NUM_VFAT-1:0]     expect_unstable;
  logic                                test_end;
  int                                  test_id;
  sbit_word_t                          base;
  int                                  error_count;
  int                                  failed_tests;

  // stream state, start_cyc is the cycle of each chip's first sof
  int t;
  int start_cyc [`SBIT_NUM_VFAT];

  always #10 fastclock = ~fastclock;

  sbit_rx_top i_sbit_rx_top (
    .fastclock    (fastclock),
    .reset        (reset),
    .data_pins    (data_pins),
    .sof_line     (sof_line),
    .mask         (mask),
    .sbits        (sbits),
    .sbits_strobe (sbits_strobe),
    .aligned      (aligned),
    .unstable     (unstable)
  );

  sbit_checker i_checker (
    .fastclock       (fastclock),
    .reset           (reset),
    .sbits           (sbits),
    .sbits_strobe    (sbits_strobe),
    .aligned         (aligned),
    .unstable        (unstable),
    .mask            (mask),
    .expect_unstable (expect_unstable),
    .test_id         (test_id),
    .base            (base),
    .test_end        (test_end),
    .error_count     (error_count),
    .failed_tests    (failed_tests)
  );

  // --------------------
  // one cycle of serial streams
  // --------------------
  // frame n carries base + n in every byte, msb first from the sof cycle
  task automatic drive_cycle();
    int         rel;
    int         pos;
    int         frame;
    logic [7:0] byte_val;
    @(posedge fastclock);
    for (int c = 0; c < `SBIT_NUM_VFAT; c++) begin
      rel = t - start_cyc[c];
      if (rel < 0) begin
        sof_line[c]  <= 1'b0;
        data_pins[c] <= '0;
      end else begin
        pos   = rel % `SBIT_FRAME_LEN;
        frame = rel / `SBIT_FRAME_LEN;
        sof_line[c] <= (pos == 0);
        for (int p = 0; p < `SBIT_NUM_PINS; p++) begin
          byte_val = base[p*8 +: 8] + 8'(frame);
          data_pins[c][p] <= byte_val[`SBIT_FRAME_LEN-1-pos];
        end
      end
    end
    t++;
  endtask

  initial begin
    int         fd;
    int         n;
    int         tests_run;
    int         lock_timeouts;
    int         id_in;
    int         off0;
    int         off1;
    int         mask_in;
    int         frames;
    int         shift0;
    int         wait_cnt;
    logic       shifted;
    string      line;
    sbit_word_t base_in;

    fastclock       = 1'b0;
    reset           = 1'b1;
    data_pins       = '0;
    sof_line        = '0;
    mask            = '0;
    expect_unstable = '0;
    test_end        = 1'b0;
    test_id         = 0;
    base            = '0;
    tests_run       = 0;
    lock_timeouts   = 0;

    fd = $fopen("sbit_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sbit_stim.txt");
      $display("Simulation finished: FAIL");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%d %d %d %h %h %d %d",
                    id_in, off0, off1, mask_in, base_in, frames, shift0);
        if (n != 7) continue;

        // reset before every test so the sticky flag starts clear
        @(posedge fastclock);
        test_id         <= id_in;
        base            <= base_in;
        mask            <= mask_in[`SBIT_NUM_VFAT-1:0];
        expect_unstable <= {1'b0, (shift0 < `SBIT_FRAME_LEN)};
        reset           <= 1'b1;
        sof_line        <= '0;
        data_pins       <= '0;
        repeat (2) @(posedge fastclock);
        reset <= 1'b0;
        t            = 0;
        start_cyc[0] = off0;
        start_cyc[1] = off1;
        shifted      = 1'b0;

        // wait for every unmasked chip to lock
        wait_cnt = 0;
        while (((aligned | mask) != '1) && wait_cnt < LOCK_TIMEOUT) begin
          drive_cycle();
          wait_cnt++;
        end
        if (wait_cnt >= LOCK_TIMEOUT) begin
          $display("test %0d: lock wait timed out after %0d cycles", test_id, LOCK_TIMEOUT);
          lock_timeouts++;
        end

        // data run, chip 0 may jump to a new offset half way
        for (int i = 0; i < frames * `SBIT_FRAME_LEN; i++) begin
          if (!shifted && shift0 < `SBIT_FRAME_LEN && i >= frames * 4 &&
              (t - start_cyc[0]) % `SBIT_FRAME_LEN == 0) begin
            start_cyc[0] = t + `SBIT_FRAME_LEN + shift0;
            shifted      = 1'b1;
          end
          drive_cycle();
        end

        @(posedge fastclock);
        test_end <= 1'b1;
        @(posedge fastclock);
        test_end <= 1'b0;
        @(posedge fastclock);
        tests_run++;
      end
      $fclose(fd);

      $display("tests run %0d, tests failed %0d, errors %0d, lock timeouts %0d",
               tests_run, failed_tests, error_count, lock_timeouts);
      if (error_count == 0 && lock_timeouts == 0 && tests_run > 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
